// ==== mf2_cfg.svh ====
////////////////////
// Fixed MF2 map. The RAM is 8 KB and the shadow slots sit at the
// addresses the MF2 firmware expects, so none of this is tunable
////////////////////
`ifndef MF2_CFG_SVH
`define MF2_CFG_SVH

// Bus and RAM widths
`define MF2_CPU_AW      16
`define MF2_CPU_DW      8
`define MF2_RAM_AW      13
`define MF2_PEN_IDX_W   5
`define MF2_CRTC_IDX_W  4

// Fetch vectors
`define MF2_NMI_VEC     16'h0066
`define MF2_HIDE_VEC    16'h0065

// FEE8 pages in, FEEA pages out
`define MF2_PAGE_PORT   14'b11111110111010

// Port high bytes of the shadowed hardware
`define GA_PORT         8'h7F
`define CRTC_SEL_PORT   8'hBC
`define CRTC_VAL_PORT   8'hBD
`define PPI_PORT        8'hF7
`define UROM_PORT       8'hDF

// Shadow slots in MF2 RAM
`define SLOT_PEN        13'h1FCF
`define SLOT_BORDER     13'h1FDF
`define SLOT_PEN_BASE   13'h1F90
`define SLOT_MODE       13'h1FEF
`define SLOT_BANK       13'h1FFF
`define SLOT_CRTC_SEL   13'h1CFF
`define SLOT_CRTC_BASE  13'h1DB0
`define SLOT_PPI        13'h17FF
`define SLOT_UROM       13'h1AAC

`endif

// ==== mf2_pkg.sv ====
////////////////////
// Types shared by the MF2 stages. Widths follow the cfg header
////////////////////
`include "mf2_cfg.svh"

package mf2_pkg;

	typedef logic [`MF2_CPU_AW-1:0] cpu_addr_t;
	typedef logic [`MF2_CPU_DW-1:0] cpu_data_t;
	typedef logic [`MF2_RAM_AW-1:0] mf2_addr_t;

	// CPU bus as seen by the device. All strobes are levels
	typedef struct packed {
		cpu_addr_t addr;
		cpu_data_t wdata;
		logic      m1;
		logic      io_wr;
		logic      mem_rd;
		logic      mem_wr;
	} cpu_bus_t;

	// Decoded cycle handed to control and RAM
	typedef struct packed {
		logic      nmi_key_edge;
		logic      fetch_nmi_vec;
		logic      fetch_hide_vec;
		logic      page_in_req;
		logic      page_out_req;
		logic      store_req;
		logic      cpu_wr;
		mf2_addr_t slot;
		cpu_data_t wdata;
		// Address only, not qualified by the page state
		logic      win_rom;
		logic      win_ram;
	} mf2_op_t;

	typedef enum logic [1:0] {
		MODE_ENABLED,
		MODE_HIDDEN,
		MODE_DISABLED
	} mf2_mode_e;

	typedef enum logic [1:0] {
		ST_OFF,
		ST_NMI_PENDING,
		ST_ACTIVE
	} mf2_state_e;

endpackage

// ==== mf2_bus_decode.sv ====
////////////////////
// Events are valid in the first cycle a strobe reads high. The bus
// must hold address and data stable while the strobe stays high
////////////////////
`timescale 1ns/1ps
`include "mf2_cfg.svh"

module mf2_bus_decode (
	input  logic              clk_sys,
	input  logic              reset,
	input  mf2_pkg::cpu_bus_t bus,
	input  logic              key_nmi,
	output mf2_pkg::mf2_op_t  op
);
	import mf2_pkg::*;

	// Previous strobe levels
	logic m1_q;
	logic io_wr_q;
	logic key_q;

	// Last pen index and CRTC register written by the CPU
	logic [`MF2_PEN_IDX_W-1:0]  pen_idx;
	logic [`MF2_CRTC_IDX_W-1:0] crtc_reg;

	logic      m1_edge;
	logic      io_edge;
	logic      page_hit;
	logic      slot_vld;
	mf2_addr_t slot;
	logic [7:0] port_hi;
	logic [1:0] ga_fn;

	assign port_hi = bus.addr[15:8];
	assign ga_fn   = bus.wdata[7:6];
	assign m1_edge = bus.m1 & ~m1_q;
	assign io_edge = bus.io_wr & ~io_wr_q;

	assign page_hit = io_edge & (bus.addr[15:2] == `MF2_PAGE_PORT);

	////////////////////
	// Shadow slot lookup
	////////////////////
	always_comb begin
		slot     = '0;
		slot_vld = 1'b1;
		case (port_hi)
			`GA_PORT: begin
				// Gate array function sits in data bits 7:6
				case (ga_fn)
					2'b00: slot = `SLOT_PEN;
					2'b01: begin
						if (pen_idx[`MF2_PEN_IDX_W-1]) begin
							slot = `SLOT_BORDER;
						end else begin
							slot = `SLOT_PEN_BASE + mf2_addr_t'(pen_idx[3:0]);
						end
					end
					2'b10: slot = `SLOT_MODE;
					default: slot = `SLOT_BANK;
				endcase
			end
			`CRTC_SEL_PORT: slot = `SLOT_CRTC_SEL;
			`CRTC_VAL_PORT: slot = `SLOT_CRTC_BASE + mf2_addr_t'(crtc_reg);
			`PPI_PORT:      slot = `SLOT_PPI;
			`UROM_PORT:     slot = `SLOT_UROM;
			default: begin
				slot_vld = 1'b0;
			end
		endcase
	end

	////////////////////
	// Op fields
	////////////////////
	always_comb begin
		op.nmi_key_edge   = key_nmi & ~key_q;
		op.fetch_nmi_vec  = m1_edge & (bus.addr == `MF2_NMI_VEC);
		op.fetch_hide_vec = m1_edge & (bus.addr == `MF2_HIDE_VEC);
		// Address bit 1 picks FEEA over FEE8
		op.page_in_req    = page_hit & ~bus.addr[1];
		op.page_out_req   = page_hit & bus.addr[1];
		op.store_req      = io_edge & ~page_hit & slot_vld;
		op.cpu_wr         = bus.mem_wr;
		op.slot           = slot;
		op.wdata          = bus.wdata;
		op.win_rom        = (bus.addr[15:13] == 3'b000);
		op.win_ram        = (bus.addr[15:13] == 3'b001);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q     <= 1'b0;
			io_wr_q  <= 1'b0;
			key_q    <= 1'b0;
			pen_idx  <= '0;
			crtc_reg <= '0;
		end else begin
			m1_q    <= bus.m1;
			io_wr_q <= bus.io_wr;
			key_q   <= key_nmi;
			// Pen select write
			if (op.store_req && port_hi == `GA_PORT && ga_fn == 2'b00) begin
				pen_idx <= bus.wdata[`MF2_PEN_IDX_W-1:0];
			end
			if (op.store_req && port_hi == `CRTC_SEL_PORT) begin
				crtc_reg <= bus.wdata[`MF2_CRTC_IDX_W-1:0];
			end
		end
	end

endmodule

// ==== mf2_control.sv ====
////////////////////
// Page state and NMI change one cycle after the event. Mode is
// sampled in reset and at each event
////////////////////
`timescale 1ns/1ps
`include "mf2_cfg.svh"

module mf2_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::mf2_mode_e mode,
	input  mf2_pkg::mf2_op_t   op,
	input  mf2_pkg::cpu_addr_t bus_addr,
	output logic               nmi,
	output logic               rom_en,
	output logic               ram_en
);
	import mf2_pkg::*;

	mf2_state_e state_q;
	mf2_state_e state_d;
	logic       hidden_q;
	logic       hidden_d;
	logic       disabled;
	logic       active;
	logic       in_window;

	assign disabled = (mode == MODE_DISABLED);

	////////////////////
	// Page-in FSM
	////////////////////
	always_comb begin
		state_d  = state_q;
		hidden_d = hidden_q;
		case (state_q)
			ST_OFF: begin
				if (op.nmi_key_edge && !disabled) begin
					state_d = ST_NMI_PENDING;
				end
			end
			ST_NMI_PENDING: begin
				// CPU has taken the NMI
				if (op.fetch_nmi_vec) begin
					state_d  = ST_ACTIVE;
					hidden_d = 1'b0;
				end
			end
			ST_ACTIVE: begin
				if (op.fetch_hide_vec) begin
					hidden_d = 1'b1;
				end
			end
			default: begin
				state_d = ST_OFF;
			end
		endcase

		// Port writes act from any state
		if (op.page_out_req) begin
			state_d = ST_OFF;
		end else if (op.page_in_req && !hidden_q && !disabled) begin
			state_d = ST_ACTIVE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q  <= ST_OFF;
			hidden_q <= (mode != MODE_ENABLED);
		end else begin
			state_q  <= state_d;
			hidden_q <= hidden_d;
		end
	end

	////////////////////
	// Outputs
	////////////////////
	assign nmi    = (state_q == ST_NMI_PENDING);
	assign active = (state_q == ST_ACTIVE);

	// Bit 13 splits the 16 KB MF2 area into ROM and RAM
	assign in_window = op.win_rom | op.win_ram;
	assign rom_en    = active & in_window & ~bus_addr[`MF2_RAM_AW];
	assign ram_en    = active & in_window & bus_addr[`MF2_RAM_AW];

endmodule

// ==== mf2_ram.sv ====
////////////////////
// Writes land two cycles after the event. Read data lags a stable
// address by two cycles and reads FF outside ram_en with mem_rd
////////////////////
`timescale 1ns/1ps
`include "mf2_cfg.svh"

module mf2_ram (
	input  logic              clk_sys,
	input  logic              reset,
	input  mf2_pkg::mf2_op_t  op,
	input  mf2_pkg::cpu_bus_t bus,
	input  logic              ram_en,
	output mf2_pkg::cpu_data_t rd_data
);
	import mf2_pkg::*;

	localparam int unsigned DEPTH = 1 << `MF2_RAM_AW;

	cpu_data_t mem [DEPTH];
	mf2_addr_t ram_a;
	mf2_addr_t cpu_a;
	cpu_data_t ram_in;
	cpu_data_t ram_out;
	logic      wr_pend;
	logic      cpu_wr_hit;

	assign cpu_a      = bus.addr[`MF2_RAM_AW-1:0];
	assign cpu_wr_hit = op.cpu_wr & ram_en;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_pend <= 1'b0;
		end else begin
			wr_pend <= op.store_req | cpu_wr_hit;
		end
	end

	// Store beats a CPU write, otherwise track the CPU address
	always_ff @(posedge clk_sys) begin
		ram_in <= op.wdata;
		if (op.store_req) begin
			ram_a <= op.slot;
		end else begin
			ram_a <= cpu_a;
		end
	end

	////////////////////
	// Array
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (wr_pend) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	assign rd_data = (ram_en && bus.mem_rd) ? ram_out : 8'hFF;

endmodule

// ==== mf2_top.sv ====
////////////////////
// MF2 as a bus peripheral. ROM contents live outside, only rom_en
////////////////////
`timescale 1ns/1ps

module mf2_top (
	input  logic               clk_sys,
	input  logic               reset,
	input  mf2_pkg::cpu_bus_t  bus,
	input  logic               key_nmi,
	input  mf2_pkg::mf2_mode_e mode,
	output logic               nmi,
	output logic               rom_en,
	output logic               ram_en,
	output mf2_pkg::cpu_data_t rd_data
);
	import mf2_pkg::*;

	mf2_op_t op;

	// Decode stage
	mf2_bus_decode u_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.key_nmi (key_nmi),
		.op      (op)
	);

	// Page state and windows
	mf2_control u_control (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.mode     (mode),
		.op       (op),
		.bus_addr (bus.addr),
		.nmi      (nmi),
		.rom_en   (rom_en),
		.ram_en   (ram_en)
	);

	// 8 KB RAM with shadow stores
	mf2_ram u_ram (
		.clk_sys (clk_sys),
		.reset   (reset),
		.op      (op),
		.bus     (bus),
		.ram_en  (ram_en),
		.rd_data (rd_data)
	);

endmodule

// ==== tb_mf2_assertions.sv ====
////////////////////
// Bound to mf2_top. Output rules checked on every rising clock edge
////////////////////
`timescale 1ns/1ps

module tb_mf2_assertions (
	input logic               clk_sys,
	input logic               reset,
	input mf2_pkg::cpu_bus_t  bus,
	input logic               nmi,
	input logic               rom_en,
	input logic               ram_en,
	input mf2_pkg::cpu_data_t rd_data
);

	// Count of failed assertions
	int n_fail = 0;

	// NMI pending and paged RAM are separate states
	a_nmi_ram: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && ram_en))
	else begin
		$error("nmi and ram_en high together");
		n_fail++;
	end

	// Bit 13 splits the window
	a_rom_ram: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_en && ram_en))
	else begin
		$error("rom_en and ram_en high together");
		n_fail++;
	end

	a_rd_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!bus.mem_rd |-> rd_data == 8'hFF)
	else begin
		$error("rd_data driven without mem_rd");
		n_fail++;
	end

	// Outputs stay low while reset holds
	a_reset_quiet: assert property (@(posedge clk_sys)
		reset |-> (nmi !== 1'b1) && (rom_en !== 1'b1) && (ram_en !== 1'b1))
	else begin
		$error("output high during reset");
		n_fail++;
	end

endmodule

bind mf2_top tb_mf2_assertions u_assert (
	.clk_sys (clk_sys),
	.reset   (reset),
	.bus     (bus),
	.nmi     (nmi),
	.rom_en  (rom_en),
	.ram_en  (ram_en),
	.rd_data (rd_data)
);

// ==== tb_mf2.sv ====
////////////////////
// Random checks of mf2_top against a reference model. Each bus cycle
// holds its strobe 4 cycles and idles 2, inputs change on falling edges
////////////////////
`timescale 1ns/1ps
`include "mf2_cfg.svh"

module tb_mf2;
	import mf2_pkg::*;

	localparam int CYC_M1 = 0;
	localparam int CYC_IO = 1;
	localparam int CYC_RD = 2;
	localparam int CYC_WR = 3;

	logic      clk_sys;
	logic      reset;
	cpu_bus_t  bus;
	logic      key_nmi;
	mf2_mode_e mode;
	logic      nmi;
	logic      rom_en;
	logic      ram_en;
	cpu_data_t rd_data;

	// Reference model
	mf2_state_e                 m_state;
	logic                       m_hidden;
	logic [`MF2_PEN_IDX_W-1:0]  m_pen;
	logic [`MF2_CRTC_IDX_W-1:0] m_crtc;
	cpu_data_t                  m_mem [1 << `MF2_RAM_AW];

	logic [31:0] rng;
	int          n_checks;
	int          n_value_err;
	int          n_timeout;

	mf2_top dut0 (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.key_nmi (key_nmi),
		.mode    (mode),
		.nmi     (nmi),
		.rom_en  (rom_en),
		.ram_en  (ram_en),
		.rd_data (rd_data)
	);

	always #4 clk_sys = ~clk_sys;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic cpu_data_t shadow_port(input logic [2:0] k);
		if (k == 3'd0) return `GA_PORT;
		else if (k == 3'd1) return `CRTC_SEL_PORT;
		else if (k == 3'd2) return `CRTC_VAL_PORT;
		else if (k == 3'd3) return `PPI_PORT;
		else return `UROM_PORT;
	endfunction

	////////////////////
	// Compare tasks
	////////////////////
	task automatic check_bit(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_value_err++;
			$display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input cpu_data_t exp, input cpu_data_t act);
		n_checks++;
		if (act !== exp) begin
			n_value_err++;
			$display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic wait_nmi(input logic level, input int limit);
		int n;
		n = 0;
		while (nmi !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (nmi !== level) begin
			n_timeout++;
			$display("Timeout at %0t: nmi did not reach %b within %0d cycles",
				$time, level, limit);
		end
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic bus_cycle(input int kind, input cpu_addr_t a, input cpu_data_t d,
			output cpu_data_t rd);
		bus.addr   = a;
		bus.wdata  = d;
		bus.m1     = (kind == CYC_M1);
		bus.io_wr  = (kind == CYC_IO);
		bus.mem_rd = (kind == CYC_RD);
		bus.mem_wr = (kind == CYC_WR);
		repeat (4) @(negedge clk_sys);
		rd = rd_data;
		bus.m1     = 1'b0;
		bus.io_wr  = 1'b0;
		bus.mem_rd = 1'b0;
		bus.mem_wr = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	////////////////////
	// Model plus stimulus
	////////////////////
	function automatic logic exp_ram(input cpu_addr_t a);
		return (m_state == ST_ACTIVE) && (a >= 16'h2000) && (a < 16'h4000);
	endfunction

	task automatic fetch(input cpu_addr_t a);
		cpu_data_t rd;
		bus_cycle(CYC_M1, a, 8'h00, rd);
		if (m_state == ST_NMI_PENDING && a == `MF2_NMI_VEC) begin
			m_state  = ST_ACTIVE;
			m_hidden = 1'b0;
		end else if (m_state == ST_ACTIVE && a == `MF2_HIDE_VEC) begin
			m_hidden = 1'b1;
		end
	endtask

	task automatic port_out(input cpu_addr_t a, input cpu_data_t d, output mf2_addr_t slot);
		cpu_data_t rd;
		logic      hit;
		bus_cycle(CYC_IO, a, d, rd);
		hit  = 1'b0;
		slot = '0;
		if (a[15:2] == `MF2_PAGE_PORT) begin
			if (a[1]) m_state = ST_OFF;
			else if (!m_hidden && mode != MODE_DISABLED) m_state = ST_ACTIVE;
		end else if (a[15:8] == `GA_PORT) begin
			hit = 1'b1;
			if (d[7:6] == 2'b00) begin
				slot  = `SLOT_PEN;
				m_pen = d[4:0];
			end else if (d[7:6] == 2'b01) begin
				// Pen 16 and up is the border
				slot = (m_pen >= 16) ? `SLOT_BORDER : `SLOT_PEN_BASE + m_pen[3:0];
			end else if (d[7:6] == 2'b10) begin
				slot = `SLOT_MODE;
			end else begin
				slot = `SLOT_BANK;
			end
		end else if (a[15:8] == `CRTC_SEL_PORT) begin
			hit    = 1'b1;
			slot   = `SLOT_CRTC_SEL;
			m_crtc = d[`MF2_CRTC_IDX_W-1:0];
		end else if (a[15:8] == `CRTC_VAL_PORT) begin
			hit  = 1'b1;
			slot = `SLOT_CRTC_BASE + m_crtc;
		end else if (a[15:8] == `PPI_PORT || a[15:8] == `UROM_PORT) begin
			hit  = 1'b1;
			slot = (a[15:8] == `PPI_PORT) ? `SLOT_PPI : `SLOT_UROM;
		end
		if (hit) m_mem[slot] = d;
	endtask

	task automatic mem_write(input cpu_addr_t a, input cpu_data_t d);
		cpu_data_t rd;
		bus_cycle(CYC_WR, a, d, rd);
		if (exp_ram(a)) m_mem[a[`MF2_RAM_AW-1:0]] = d;
	endtask

	task automatic mem_read_check(input cpu_addr_t a);
		cpu_data_t rd;
		cpu_data_t exp;
		exp = exp_ram(a) ? m_mem[a[`MF2_RAM_AW-1:0]] : 8'hFF;
		bus_cycle(CYC_RD, a, 8'h00, rd);
		check_data($sformatf("rd_data@%h", a), exp, rd);
	endtask

	task automatic check_windows(input cpu_addr_t a);
		bus.addr = a;
		@(negedge clk_sys);
		check_bit($sformatf("rom_en@%h", a), m_state == ST_ACTIVE && a < 16'h2000, rom_en);
		check_bit($sformatf("ram_en@%h", a), exp_ram(a), ram_en);
	endtask

	task automatic press_key();
		logic exp;
		key_nmi = 1'b1;
		if (m_state == ST_OFF && mode != MODE_DISABLED) m_state = ST_NMI_PENDING;
		exp = (m_state == ST_NMI_PENDING);
		wait_nmi(exp, 8);
		repeat (3) @(negedge clk_sys);
		check_bit("nmi", exp, nmi);
		key_nmi = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic enter_nmi();
		press_key();
		fetch(`MF2_NMI_VEC);
		check_bit("nmi", 1'b0, nmi);
	endtask

	initial begin
		logic [31:0] r;
		mf2_addr_t   slot;
		cpu_addr_t   wq[$];
		clk_sys     = 1'b0;
		reset       = 1'b1;
		key_nmi     = 1'b0;
		mode        = MODE_ENABLED;
		bus         = '0;
		rng         = 32'd41453;
		n_checks    = 0;
		n_value_err = 0;
		n_timeout   = 0;
		m_state     = ST_OFF;
		m_hidden    = (mode != MODE_ENABLED);
		m_pen       = '0;
		m_crtc      = '0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// Quiet after reset
		check_bit("nmi", 1'b0, nmi);
		check_windows(16'h0100);
		check_windows(16'h2100);
		mem_read_check(16'h2000);

		enter_nmi();
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			check_windows({2'b00, r[13:0]});
			check_windows(r[31:16]);
		end

		// CPU writes and reads in the RAM window
		for (int i = 0; i < 24; i++) begin
			r = next_rand();
			mem_write({3'b001, r[12:0]}, r[20:13]);
			wq.push_back({3'b001, r[12:0]});
		end
		foreach (wq[i]) mem_read_check(wq[i]);
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			mem_read_check(r[15:0] | 16'h4000);
			mem_read_check({3'b000, r[28:16]});
		end

		// Register shadowing
		for (int i = 0; i < 48; i++) begin
			r = next_rand();
			port_out({shadow_port(3'(r % 5)), r[15:8]}, r[23:16], slot);
			mem_read_check(16'h2000 + slot);
		end

		////////////////////
		// Paging
		////////////////////
		port_out(16'hFEEA, 8'h00, slot);
		check_windows(16'h0100);
		check_windows(16'h2100);
		port_out(16'hFEE8, 8'h00, slot);
		check_windows(16'h0100);
		check_windows(16'h2100);
		fetch(`MF2_HIDE_VEC);
		port_out(16'hFEEA, 8'h00, slot);
		port_out(16'hFEE8, 8'h00, slot);
		check_windows(16'h0100);
		check_windows(16'h2100);
		enter_nmi();
		check_windows(16'h0100);
		check_windows(16'h2100);
		port_out(16'hFEEA, 8'h00, slot);
		mode = MODE_DISABLED;
		press_key();
		port_out(16'hFEE8, 8'h00, slot);
		check_windows(16'h0100);
		check_windows(16'h2100);

		$display("Checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			n_checks, n_value_err, n_timeout, dut0.u_assert.n_fail);
		if (n_value_err == 0 && n_timeout == 0 && dut0.u_assert.n_fail == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+.
mf2_pkg.sv
mf2_bus_decode.sv
mf2_control.sv
mf2_ram.sv
mf2_top.sv
tb_mf2_assertions.sv
tb_mf2.sv

// ==== Bender.yml ====
package:
  name: mf2_periph

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mf2_pkg.sv
      - mf2_bus_decode.sv
      - mf2_control.sv
      - mf2_ram.sv
      - mf2_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mf2_assertions.sv
      - tb_mf2.sv
